//--- fetch_pkg.sv
`default_nettype none

package fetch_pkg;

   // Byte address and raw instruction word.
   typedef logic [31:0] addr_t;
   typedef logic [31:0] inst_t;

   // Number of instructions held in one cache line.
   localparam int WORDS_PER_LINE = 4;

   // A cache line carries word 0 in its low bits.
   typedef logic [WORDS_PER_LINE*32-1:0] line_t;

   // Opcode of the unconditional jump.
   localparam logic [5:0] OP_JUMP = 6'b000010;

   // The same instruction word seen as R-format or as J-format.
   typedef union packed {
      struct packed {
         logic [5:0] opcode;
         logic [4:0] rs;
         logic [4:0] rt;
         logic [4:0] rd;
         logic [4:0] shamt;
         logic [5:0] funct;
      } r;
      struct packed {
         logic [5:0]  opcode;
         logic [25:0] target;
      } j;
   } inst_u;

endpackage

`default_nettype wire

//--- icache.sv
`default_nettype none
`timescale 1ns/1ps

module icache #(
   parameter int ICACHE_LINES = 64
) (
   input  logic                            clk,
   input  logic                            rst_n,
   // Preload port.
   input  logic                            load_en,
   input  logic [$clog2(ICACHE_LINES)-1:0] load_line,
   input  fetch_pkg::line_t                load_data,
   // Read port towards the fetch queue.
   input  logic                            icache_ren,
   input  fetch_pkg::addr_t                icache_addr,
   input  logic                            icache_abort,
   output fetch_pkg::line_t                icache_line,
   output logic                            icache_valid
);

   // Index width of the line array.
   localparam int IDX_W = $clog2(ICACHE_LINES);

   // Byte offset bits inside one line, four bytes per instruction.
   localparam int OFF_W = $clog2(fetch_pkg::WORDS_PER_LINE * 4);

   fetch_pkg::line_t line_mem [ICACHE_LINES];

   logic [IDX_W-1:0] rd_index;

   // The address is taken modulo the array size, so upper bits are ignored.
   assign rd_index = icache_addr[OFF_W +: IDX_W];

   // Preload writes.
   // There is no miss handling, so the array is filled before fetch starts.
   always_ff @(posedge clk) begin
      if (load_en) begin
         line_mem[load_line] <= load_data;
      end
   end

   // The line is captured on every strobe.
   // Only the valid flag decides whether the queue takes it.
   always_ff @(posedge clk) begin
      if (icache_ren) begin
         icache_line <= line_mem[rd_index];
      end
   end

   // An abort in the strobe cycle cancels the answer one cycle later.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         icache_valid <= 1'b0;
      end else begin
         icache_valid <= icache_ren & ~icache_abort;
      end
   end

endmodule

`default_nettype wire

//--- ifq.sv
`default_nettype none
`timescale 1ns/1ps

module ifq #(
   parameter int IFQ_LINES = 4
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             fetch_en,
   // Instruction cache side.
   output logic             icache_ren,
   output logic             icache_abort,
   output fetch_pkg::addr_t icache_addr,
   input  fetch_pkg::line_t icache_line,
   input  logic             icache_valid,
   // Dispatch side.
   output fetch_pkg::inst_t q_inst,
   output fetch_pkg::addr_t q_pc_plus4,
   output logic             q_empty,
   input  logic             q_ren,
   input  logic             br_valid,
   input  fetch_pkg::addr_t br_addr
);

   // Word offset bits inside a line.
   localparam int WB = $clog2(fetch_pkg::WORDS_PER_LINE);

   // Slot index bits, plus one wrap bit for the line pointers.
   localparam int SLOT_W = $clog2(IFQ_LINES);
   localparam int LP_W   = SLOT_W + 1;
   localparam int RP_W   = LP_W + WB;

   localparam int LINE_BYTES = fetch_pkg::WORDS_PER_LINE * 4;
   localparam int INST_W     = $bits(fetch_pkg::inst_t);

   localparam fetch_pkg::addr_t LINE_STEP = fetch_pkg::addr_t'(LINE_BYTES);
   localparam fetch_pkg::addr_t LINE_MASK = ~fetch_pkg::addr_t'(LINE_BYTES - 1);

   fetch_pkg::line_t line_mem [IFQ_LINES];

   // The write pointer counts lines, the read pointer counts words.
   logic [LP_W-1:0] wptr_r;
   logic [LP_W-1:0] wptr_next;
   logic [RP_W-1:0] rptr_r;
   logic [RP_W-1:0] rptr_next;
   logic [LP_W-1:0] rd_line;
   logic [LP_W-1:0] rd_line_next;
   logic [WB-1:0]   rd_word;

   fetch_pkg::addr_t fetch_addr_r;
   fetch_pkg::addr_t rd_pc_r;

   logic is_empty;
   logic is_full;
   logic next_full;
   logic bypass;
   logic consume;
   logic write_line;
   logic fetch_req;

   fetch_pkg::line_t stored_line;
   fetch_pkg::inst_t stored_word;
   fetch_pkg::inst_t bypass_word;

   assign rd_line      = rptr_r[WB +: LP_W];
   assign rd_word      = rptr_r[WB-1:0];
   assign rd_line_next = rptr_next[WB +: LP_W];

   // Equal slots with equal wrap bits mean empty, with different wrap bits full.
   assign is_empty  = (wptr_r == rd_line);
   assign is_full   = (wptr_r[SLOT_W] != rd_line[SLOT_W]) &&
                      (wptr_r[SLOT_W-1:0] == rd_line[SLOT_W-1:0]);
   assign next_full = (wptr_next[SLOT_W] != rd_line_next[SLOT_W]) &&
                      (wptr_next[SLOT_W-1:0] == rd_line_next[SLOT_W-1:0]);

   // When nothing is stored, the line arriving now is the one the read
   // pointer waits for, so its word is shown directly.
   assign bypass  = is_empty & icache_valid;
   assign q_empty = bypass ? 1'b0 : is_empty;
   assign consume = q_ren & ~q_empty;

   // A line that lands in the redirect cycle belongs to the old path.
   assign write_line = icache_valid & ~br_valid & ~is_full;

   assign stored_line = line_mem[rd_line[SLOT_W-1:0]];
   assign stored_word = stored_line[rd_word*INST_W +: INST_W];
   assign bypass_word = icache_line[rd_word*INST_W +: INST_W];

   assign q_inst     = bypass ? bypass_word : stored_word;
   assign q_pc_plus4 = rd_pc_r + 32'd4;

   // On a redirect both pointers restart at slot 0.
   // The read pointer keeps the word offset of the target.
   assign rptr_next = br_valid ? {{LP_W{1'b0}}, br_addr[2 +: WB]} :
                      consume  ? rptr_r + 1'b1 : rptr_r;
   assign wptr_next = br_valid   ? '0 :
                      write_line ? wptr_r + 1'b1 : wptr_r;

   // A request is made only if its answer will find a free slot.
   assign icache_ren   = fetch_en & ~next_full;
   assign icache_addr  = fetch_addr_r;
   assign icache_abort = br_valid & icache_ren;
   assign fetch_req    = icache_ren & ~icache_abort;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wptr_r       <= '0;
         rptr_r       <= '0;
         fetch_addr_r <= '0;
         rd_pc_r      <= '0;
      end else begin
         wptr_r <= wptr_next;
         rptr_r <= rptr_next;
         if (br_valid) begin
            fetch_addr_r <= br_addr & LINE_MASK;
            rd_pc_r      <= {br_addr[31:2], 2'b00};
         end else begin
            if (fetch_req) begin
               fetch_addr_r <= fetch_addr_r + LINE_STEP;
            end
            if (consume) begin
               rd_pc_r <= rd_pc_r + 32'd4;
            end
         end
      end
   end

   // Line storage.
   // A bypassed line is written as well, since the read pointer stays on it
   // until its last word is consumed.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < IFQ_LINES; i++) begin
            line_mem[i] <= '0;
         end
      end else if (write_line) begin
         line_mem[wptr_r[SLOT_W-1:0]] <= icache_line;
      end
   end

endmodule

`default_nettype wire

//--- dispatch.sv
`default_nettype none
`timescale 1ns/1ps

module dispatch (
   input  logic             clk,
   input  logic             rst_n,
   // Fetch queue side.
   input  fetch_pkg::inst_t q_inst,
   input  fetch_pkg::addr_t q_pc_plus4,
   input  logic             q_empty,
   output logic             q_ren,
   output logic             br_valid,
   output fetch_pkg::addr_t br_addr,
   // Stall from later stages.
   input  logic             hold,
   // Issue record.
   output logic             issue_valid,
   output logic             issue_is_jump,
   output fetch_pkg::addr_t issue_pc,
   output fetch_pkg::inst_t issue_inst,
   output logic [4:0]       issue_rs,
   output logic [4:0]       issue_rt,
   output logic [4:0]       issue_rd
);

   fetch_pkg::inst_u word;

   logic is_jump;

   assign word = q_inst;

   // One instruction per cycle whenever the queue has one and nothing stalls.
   assign q_ren = ~hold & ~q_empty;

   assign is_jump = (word.j.opcode == fetch_pkg::OP_JUMP);

   // Jump target keeps the region bits of the following pc.
   assign br_addr  = {q_pc_plus4[31:28], word.j.target, 2'b00};
   assign br_valid = q_ren & is_jump;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         issue_valid <= 1'b0;
      end else begin
         issue_valid <= q_ren;
      end
   end

   // The record is only loaded when an instruction is taken.
   // It holds its last value otherwise.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         issue_is_jump <= 1'b0;
         issue_pc      <= '0;
         issue_inst    <= '0;
         issue_rs      <= '0;
         issue_rt      <= '0;
         issue_rd      <= '0;
      end else if (q_ren) begin
         issue_is_jump <= is_jump;
         issue_pc      <= q_pc_plus4 - 32'd4;
         issue_inst    <= q_inst;
         if (is_jump) begin
            // J-format has no register operands.
            issue_rs <= '0;
            issue_rt <= '0;
            issue_rd <= '0;
         end else begin
            issue_rs <= word.r.rs;
            issue_rt <= word.r.rt;
            issue_rd <= word.r.rd;
         end
      end
   end

endmodule

`default_nettype wire

//--- fetch_top.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_top #(
   parameter int IFQ_LINES    = 4,
   parameter int ICACHE_LINES = 64
) (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            load_en,
   input  logic [$clog2(ICACHE_LINES)-1:0] load_line,
   input  fetch_pkg::line_t                load_data,
   input  logic                            fetch_en,
   input  logic                            hold,
   output logic                            issue_valid,
   output fetch_pkg::addr_t                issue_pc,
   output fetch_pkg::inst_t                issue_inst,
   output logic                            issue_is_jump,
   output logic [4:0]                      issue_rs,
   output logic [4:0]                      issue_rt,
   output logic [4:0]                      issue_rd
);

   // Cache to queue.
   logic             icache_ren;
   logic             icache_abort;
   fetch_pkg::addr_t icache_addr;
   fetch_pkg::line_t icache_line;
   logic             icache_valid;

   // Queue to dispatch, and the redirect back.
   fetch_pkg::inst_t q_inst;
   fetch_pkg::addr_t q_pc_plus4;
   logic             q_empty;
   logic             q_ren;
   logic             br_valid;
   fetch_pkg::addr_t br_addr;

   icache #(
      .ICACHE_LINES (ICACHE_LINES)
   ) u_icache (
      .clk          (clk),
      .rst_n        (rst_n),
      .load_en      (load_en),
      .load_line    (load_line),
      .load_data    (load_data),
      .icache_ren   (icache_ren),
      .icache_addr  (icache_addr),
      .icache_abort (icache_abort),
      .icache_line  (icache_line),
      .icache_valid (icache_valid)
   );

   ifq #(
      .IFQ_LINES (IFQ_LINES)
   ) u_ifq (
      .clk          (clk),
      .rst_n        (rst_n),
      .fetch_en     (fetch_en),
      .icache_ren   (icache_ren),
      .icache_abort (icache_abort),
      .icache_addr  (icache_addr),
      .icache_line  (icache_line),
      .icache_valid (icache_valid),
      .q_inst       (q_inst),
      .q_pc_plus4   (q_pc_plus4),
      .q_empty      (q_empty),
      .q_ren        (q_ren),
      .br_valid     (br_valid),
      .br_addr      (br_addr)
   );

   dispatch u_dispatch (
      .clk           (clk),
      .rst_n         (rst_n),
      .q_inst        (q_inst),
      .q_pc_plus4    (q_pc_plus4),
      .q_empty       (q_empty),
      .q_ren         (q_ren),
      .br_valid      (br_valid),
      .br_addr       (br_addr),
      .hold          (hold),
      .issue_valid   (issue_valid),
      .issue_is_jump (issue_is_jump),
      .issue_pc      (issue_pc),
      .issue_inst    (issue_inst),
      .issue_rs      (issue_rs),
      .issue_rt      (issue_rt),
      .issue_rd      (issue_rd)
   );

endmodule

`default_nettype wire

//--- fetch_tb.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_tb;

   localparam int IFQ_LINES    = 4;
   localparam int ICACHE_LINES = 64;
   localparam int PROG_WORDS   = ICACHE_LINES * fetch_pkg::WORDS_PER_LINE;
   localparam int CLK_PERIOD   = 4;
   localparam int TOTAL_ISSUES = 48 + 16 + 20 + 200 + 40;

   logic                            clk;
   logic                            rst_n;
   logic                            load_en;
   logic [$clog2(ICACHE_LINES)-1:0] load_line;
   fetch_pkg::line_t                load_data;
   logic                            fetch_en;
   logic                            hold;
   logic                            issue_valid;
   fetch_pkg::addr_t                issue_pc;
   fetch_pkg::inst_t                issue_inst;
   logic                            issue_is_jump;
   logic [4:0]                      issue_rs;
   logic [4:0]                      issue_rt;
   logic [4:0]                      issue_rd;

   // The program image holds one word per instruction and is mirrored into the cache.
   fetch_pkg::inst_t prog [PROG_WORDS];

   logic [31:0] lfsr_state;
   string       test_name;
   int          issue_count;
   int          exp_total;
   logic        check_on;

   fetch_top #(
      .IFQ_LINES    (IFQ_LINES),
      .ICACHE_LINES (ICACHE_LINES)
   ) dut (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_en       (load_en),
      .load_line     (load_line),
      .load_data     (load_data),
      .fetch_en      (fetch_en),
      .hold          (hold),
      .issue_valid   (issue_valid),
      .issue_pc      (issue_pc),
      .issue_inst    (issue_inst),
      .issue_is_jump (issue_is_jump),
      .issue_rs      (issue_rs),
      .issue_rt      (issue_rt),
      .issue_rd      (issue_rd)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Galois LFSR that is stepped once for each bit taken.
   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr_state[0]};
         if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
         end else begin
            lfsr_state = lfsr_state >> 1;
         end
      end
      return r;
   endfunction

   // Random word that is never a jump.
   function automatic fetch_pkg::inst_t plain_inst();
      fetch_pkg::inst_t w;
      w = rand_bits(32);
      if (w[31:26] == fetch_pkg::OP_JUMP) begin
         w[31:26] = w[31:26] ^ 6'b000001;
      end
      return w;
   endfunction

   function automatic fetch_pkg::inst_t make_jump(fetch_pkg::addr_t target);
      return {fetch_pkg::OP_JUMP, target[27:2]};
   endfunction

   // The cache index wraps, so the program repeats every PROG_WORDS words.
   function automatic fetch_pkg::inst_t ref_word(fetch_pkg::addr_t pc);
      return prog[(pc >> 2) % PROG_WORDS];
   endfunction

   // Walks the program from pc 0 and returns the pc of issue number n.
   function automatic fetch_pkg::addr_t ref_pc(int n);
      fetch_pkg::addr_t pc;
      fetch_pkg::addr_t next;
      fetch_pkg::inst_t w;
      pc = '0;
      for (int i = 0; i < n; i++) begin
         w    = ref_word(pc);
         next = pc + 32'd4;
         if (w[31:26] == fetch_pkg::OP_JUMP) begin
            next = {next[31:28], w[25:0], 2'b00};
         end
         pc = next;
      end
      return pc;
   endfunction

   task automatic stop_run();
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_addr(string what, fetch_pkg::addr_t exp, fetch_pkg::addr_t act);
      if (act !== exp) begin
         $display("CHECK FAILED test=%s %s issue=%0d expected=%h actual=%h",
                  test_name, what, issue_count, exp, act);
         stop_run();
      end
   endtask

   task automatic check_inst(string what, fetch_pkg::inst_t exp, fetch_pkg::inst_t act);
      if (act !== exp) begin
         $display("CHECK FAILED test=%s %s issue=%0d expected=%h actual=%h",
                  test_name, what, issue_count, exp, act);
         stop_run();
      end
   endtask

   task automatic check_reg(string what, logic [4:0] exp, logic [4:0] act);
      if (act !== exp) begin
         $display("CHECK FAILED test=%s %s issue=%0d expected=%h actual=%h",
                  test_name, what, issue_count, exp, act);
         stop_run();
      end
   endtask

   task automatic check_bit(string what, logic exp, logic act);
      if (act !== exp) begin
         $display("CHECK FAILED test=%s %s issue=%0d expected=%b actual=%b",
                  test_name, what, issue_count, exp, act);
         stop_run();
      end
   endtask

   // Compares every issued record with the reference walk.
   always @(negedge clk) begin : compare_issue
      fetch_pkg::addr_t exp_pc;
      fetch_pkg::inst_t exp_word;
      logic             exp_jump;
      if (rst_n && check_on && issue_valid) begin
         exp_pc   = ref_pc(issue_count);
         exp_word = ref_word(exp_pc);
         exp_jump = (exp_word[31:26] == fetch_pkg::OP_JUMP);
         check_addr("issue_pc", exp_pc, issue_pc);
         check_inst("issue_inst", exp_word, issue_inst);
         check_bit("issue_is_jump", exp_jump, issue_is_jump);
         check_reg("issue_rs", exp_jump ? 5'd0 : exp_word[25:21], issue_rs);
         check_reg("issue_rt", exp_jump ? 5'd0 : exp_word[20:16], issue_rt);
         check_reg("issue_rd", exp_jump ? 5'd0 : exp_word[15:11], issue_rd);
         issue_count++;
         if (issue_count == exp_total) begin
            check_on = 1'b0;
         end
      end
   end

   task automatic fill_random();
      for (int i = 0; i < PROG_WORDS; i++) begin
         prog[i] = plain_inst();
      end
   endtask

   task automatic load_program();
      for (int l = 0; l < ICACHE_LINES; l++) begin
         @(posedge clk);
         #1;
         load_en   = 1'b1;
         load_line = l[$clog2(ICACHE_LINES)-1:0];
         for (int w = 0; w < fetch_pkg::WORDS_PER_LINE; w++) begin
            load_data[w*32 +: 32] = prog[l*fetch_pkg::WORDS_PER_LINE + w];
         end
      end
      @(posedge clk);
      #1;
      load_en = 1'b0;
   endtask

   // Reset, load the current program with fetch disabled, then arm the compare.
   task automatic start_test(string name, int total);
      test_name = name;
      @(posedge clk);
      #1;
      fetch_en = 1'b0;
      rst_n    = 1'b0;
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;
      load_program();
      issue_count = 0;
      exp_total   = total;
      check_on    = 1'b1;
   endtask

   task automatic await_issues();
      while (issue_count < exp_total) begin
         @(posedge clk);
      end
      #1;
      fetch_en = 1'b0;
   endtask

   task automatic expect_quiet(int cycles, string why);
      repeat (cycles) begin
         @(negedge clk);
         if (issue_valid !== 1'b0) begin
            $display("ERROR: test=%s issue_valid went high while %s", test_name, why);
            stop_run();
         end
      end
   endtask

   initial begin
      #(TOTAL_ISSUES * 40 * CLK_PERIOD);
      $display("ERROR: timeout, the issue stream stalled before all tests finished");
      $display("FAIL: see errors above");
      $fatal(1, "watchdog expired");
   end

   initial begin
      rst_n       = 1'b0;
      load_en     = 1'b0;
      load_line   = '0;
      load_data   = '0;
      fetch_en    = 1'b0;
      hold        = 1'b0;
      check_on    = 1'b0;
      issue_count = 0;
      exp_total   = 0;
      lfsr_state  = 32'h659d_9f15;

      fill_random();
      start_test("straight_line", 48);
      fetch_en = 1'b1;
      await_issues();

      // Jump from word 1 of line 1 to the start of line 8.
      fill_random();
      prog[5] = make_jump(32'h0000_0080);
      start_test("jump_aligned", 16);
      fetch_en = 1'b1;
      await_issues();

      // Targets land on word 2 and then word 3 of their lines.
      fill_random();
      prog[3]  = make_jump(32'h0000_00a8);
      prog[45] = make_jump(32'h0000_011c);
      start_test("jump_mid_line", 20);
      fetch_en = 1'b1;
      await_issues();

      // A loop over 6..10 and 16..21 with a mid-line hop inside it.
      fill_random();
      prog[10] = make_jump(32'h0000_0040);
      prog[18] = make_jump(32'h0000_004c);
      prog[21] = make_jump(32'h0000_0018);
      start_test("random_hold_loop", 200);
      fetch_en = 1'b1;
      while (issue_count < exp_total) begin
         @(posedge clk);
         #1;
         hold = (rand_bits(2) == 2'b00);
      end
      hold = 1'b0;
      await_issues();

      fill_random();
      prog[7] = make_jump(32'h0000_0034);
      start_test("fill_then_release", 40);
      expect_quiet(10, "fetch_en was low");
      @(posedge clk);
      #1;
      // Hold rises together with fetch_en, so the queue fills up.
      hold     = 1'b1;
      fetch_en = 1'b1;
      expect_quiet(20, "hold was high");
      // With the queue full no further cache read is requested.
      check_bit("icache_ren when full", 1'b0, dut.u_ifq.icache_ren);
      @(posedge clk);
      #1;
      hold = 1'b0;
      await_issues();

      repeat (4) @(posedge clk);
      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
fetch_pkg.sv
icache.sv
ifq.sv
dispatch.sv
fetch_top.sv
fetch_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the fetch front end testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module fetch_tb -f verilog.f -o sim_fetch
out=$(./obj_dir/sim_fetch) || true
echo "$out"
if echo "$out" | grep -qx 'PASS: all tests'; then
   exit 0
fi
exit 1
